// File: bench/alu_tb.sv
module alu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;

    // About 160 ops of 10 cycles each plus reset, with more than 2x margin
    localparam int MAX_CYCLES = 4000;

    logic              clk;
    logic              rst_n;
    logic [APB_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;

    integer      seed = 32'hdcac;                     // Fixed seed for $random
    int          cycles = 0;
    int          errs = 0;                            // Failed checks so far
    int          errs_at_open;
    int          ok_tests = 0;
    int          bad_tests = 0;
    string       cur_name;
    logic [31:0] exp_data;                            // Latched by read task
    logic        exp_err;                             // Expected pslverr of this access
    logic        chk_data;                            // Compare prdata on this access
    alu_res_s    last_res;                            // Model of captured flags
    logic        valid_m;
    logic        sticky_m;

    alu_apb_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Read data of every checked access
    a_prdata : assert property (
        @(posedge clk) disable iff (!rst_n) (psel && penable && chk_data) |-> (prdata == exp_data)
    ) else begin
        $display("CHECK FAILED prdata @%h: expected %h, got %h",
                 $sampled(paddr), $sampled(exp_data), $sampled(prdata));
        errs++;
    end

    // Error response on every access
    a_pslverr : assert property (
        @(posedge clk) disable iff (!rst_n) (psel && penable) |-> (pslverr == exp_err)
    ) else begin
        $display("CHECK FAILED pslverr @%h: expected %h, got %h",
                 $sampled(paddr), $sampled(exp_err), $sampled(pslverr));
        errs++;
    end

    a_pready : assert property (
        @(posedge clk) disable iff (!rst_n) (psel && penable) |-> pready
    ) else begin
        $display("CHECK FAILED pready: expected 1, got %h", $sampled(pready));
        errs++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [15:0] rand16();
        logic [31:0] v;
        v = $random(seed);
        return v[15:0];
    endfunction

    // Expected result and flags from the operation rules
    function automatic alu_res_s ref_alu(input logic [15:0] a, input logic [15:0] b,
                                         input logic [4:0] code, input logic coe_n);
        alu_res_s    r;
        int          sa;
        int          sb;
        int          exact;                           // True signed value
        logic [16:0] wide;                            // Unsigned sum with carry
        logic        arith;
        r     = '0;
        sa    = $signed(a);
        sb    = $signed(b);
        exact = 0;
        wide  = '0;
        arith = 1'b1;
        case (code)
            OP_ADD, OP_ADDU: begin
                exact = sa + sb;
                wide  = {1'b0, a} + {1'b0, b};
            end
            OP_SUB, OP_SUBU: begin
                exact = sa - sb;
                wide  = {1'b0, a} + {1'b0, ~b} + 17'd1;   // a + ~b + 1
            end
            OP_INC: begin
                exact = sa + 1;
                wide  = {1'b0, a} + 17'd1;
            end
            OP_DEC: begin
                exact = sa - 1;
                wide  = {1'b0, a} + 17'h0FFFF;            // a + ~1 + 1
            end
            default: arith = 1'b0;
        endcase
        if (arith) begin
            r.result = wide[15:0];
            r.vout   = (code != OP_ADDU) && (code != OP_SUBU)
                       && (exact > 32767 || exact < -32768);
            r.cout   = wide[16] & ~coe_n;             // Enable is active low
        end else begin
            case (code)
                OP_AND: r.result = a & b;
                OP_OR:  r.result = a | b;
                OP_XOR: r.result = a ^ b;
                OP_NOT: r.result = ~a;
                OP_SLL, OP_SLA: r.result = a << b[3:0];
                OP_SRL: r.result = a >> b[3:0];
                OP_SRA: r.result = (a >> b[3:0]) | (a[15] ? ~(16'hFFFF >> b[3:0]) : 16'h0000);
                OP_SLE: r.result = {15'd0, sa <= sb};
                OP_SLT: r.result = {15'd0, sa <  sb};
                OP_SGE: r.result = {15'd0, sa >= sb};
                OP_SGT: r.result = {15'd0, sa >  sb};
                OP_SEQ: r.result = {15'd0, sa == sb};
                OP_SNE: r.result = {15'd0, sa != sb};
                default: r.result = 16'h0000;         // Undefined codes
            endcase
        end
        return r;
    endfunction

    function automatic logic [31:0] status_word();
        return {28'd0, sticky_m, last_res.cout, last_res.vout, valid_m};
    endfunction

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic err);
        @(negedge clk);
        psel     = 1'b1;                              // Setup phase
        penable  = 1'b0;
        pwrite   = 1'b1;
        paddr    = addr;
        pwdata   = data;
        chk_data = 1'b0;
        exp_err  = err;
        @(negedge clk);
        penable = 1'b1;                               // Access phase
        @(posedge clk);
        if (!err && (addr == REG_OPA || addr == REG_OPB)) begin
            valid_m = 1'b0;                           // Inputs changed
        end
        if (!err && addr == REG_STATUS && data[STAT_OVF_BIT]) begin
            sticky_m = 1'b0;
        end
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [31:0] data, input logic err);
        @(negedge clk);
        psel     = 1'b1;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = addr;
        pwdata   = '0;
        exp_data = data;                              // Checked by a_prdata
        exp_err  = err;
        chk_data = 1'b1;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
    endtask

    task automatic bus_idle();
        @(negedge clk);
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        chk_data = 1'b0;
        exp_err  = 1'b0;
    endtask

    // One operation, then RESULT and STATUS read back to back
    task automatic run_op(input logic [15:0] a, input logic [15:0] b,
                          input logic [4:0] code, input logic coe_n);
        alu_res_s exp;
        exp = ref_alu(a, b, code, coe_n);
        write_reg(REG_OPA, {16'd0, a}, 1'b0);
        write_reg(REG_OPB, {16'd0, b}, 1'b0);
        write_reg(REG_CTRL, {23'd0, coe_n, 3'd0, code}, 1'b0);
        last_res = exp;
        valid_m  = 1'b1;
        sticky_m = sticky_m | exp.vout;
        read_reg(REG_RESULT, {16'd0, exp.result}, 1'b0);
        read_reg(REG_STATUS, status_word(), 1'b0);
    endtask

    task automatic open_test(input string name);
        cur_name     = name;
        errs_at_open = errs;
    endtask

    task automatic close_test();
        bus_idle();
        if (errs == errs_at_open) begin
            ok_tests++;
            $display("%s: ok", cur_name);
        end else begin
            bad_tests++;
            $display("%s: %0d errors", cur_name, errs - errs_at_open);
        end
    endtask

    task automatic reset_and_map();
        open_test("reset_and_map");
        read_reg(REG_STATUS, 32'h0, 1'b0);
        read_reg(REG_RESULT, 32'h0, 1'b0);
        read_reg(REG_CTRL, 32'h0, 1'b0);
        write_reg(REG_OPA, 32'h0000_1234, 1'b0);
        write_reg(REG_OPB, 32'h0000_ABCD, 1'b0);
        read_reg(REG_OPA, 32'h0000_1234, 1'b0);
        read_reg(REG_OPB, 32'h0000_ABCD, 1'b0);
        read_reg(8'h14, 32'h0, 1'b1);                 // Unmapped offset
        write_reg(8'h14, 32'hFFFF_FFFF, 1'b1);
        write_reg(REG_RESULT, 32'h0000_5555, 1'b1);   // Read only
        read_reg(REG_RESULT, 32'h0, 1'b0);            // Unchanged by bad write
        close_test();
    endtask

    task automatic arith_ops();
        open_test("arith_ops");
        run_op(16'h7FFF, 16'h0001, OP_ADD, 1'b0);     // Positive overflow
        run_op(16'h8000, 16'h0001, OP_SUB, 1'b0);     // Negative overflow
        run_op(16'hFFFF, 16'h0001, OP_ADD, 1'b0);     // Carry, no overflow
        run_op(16'hFFFF, 16'h0001, OP_ADDU, 1'b0);
        run_op(16'h0000, 16'h0001, OP_SUBU, 1'b0);    // Borrow
        run_op(16'h7FFF, 16'h0000, OP_INC, 1'b0);
        run_op(16'h8000, 16'h0000, OP_DEC, 1'b0);
        run_op(16'h0000, 16'h0000, OP_DEC, 1'b0);
        for (int i = 0; i < 6; i++) begin
            for (int c = 0; c < 6; c++) begin
                run_op(rand16(), rand16(), 5'(c), 1'b0);
            end
        end
        for (int c = 0; c < 6; c++) begin
            run_op(16'hFFFF, 16'h0001, 5'(c), 1'b1);  // Carry masked
        end
        close_test();
    endtask

    task automatic logic_and_shift();
        logic [15:0] b;
        open_test("logic_and_shift");
        for (int i = 0; i < 4; i++) begin
            run_op(rand16(), rand16(), OP_AND, 1'b0);
            run_op(rand16(), rand16(), OP_OR, 1'b0);
            run_op(rand16(), rand16(), OP_XOR, 1'b0);
            run_op(rand16(), rand16(), OP_NOT, 1'b0);
        end
        for (int n = 0; n < 16; n++) begin
            b = (rand16() & 16'hFFF0) | 16'(n);       // Upper bits must be ignored
            run_op(rand16(), b, OP_SLL, 1'b0);
            run_op(rand16(), b, OP_SRL, 1'b0);
            run_op(rand16(), b, OP_SLA, 1'b0);
            run_op(rand16(), b, OP_SRA, 1'b0);
        end
        close_test();
    endtask

    task automatic setcond_ops();
        open_test("setcond_ops");
        for (int c = 24; c < 30; c++) begin
            run_op(16'h1234, 16'h1234, 5'(c), 1'b0);  // Equal
            run_op(16'h0005, 16'hFFFD, 5'(c), 1'b0);  // Greater signed, less unsigned
            run_op(16'h8000, 16'h7FFF, 5'(c), 1'b0);  // Less
        end
        run_op(16'h7FFF, 16'h0001, 5'b01_011, 1'b0);
        run_op(16'h7FFF, 16'h0001, 5'b11_111, 1'b0);
        run_op(16'h7FFF, 16'h0001, 5'b00_110, 1'b0);  // Unused arith func
        close_test();
    endtask

    task automatic valid_and_sticky();
        open_test("valid_and_sticky");
        write_reg(REG_STATUS, 32'h0000_0008, 1'b0);   // Start from a clear sticky
        read_reg(REG_STATUS, status_word(), 1'b0);
        run_op(16'h7FFF, 16'h0001, OP_ADD, 1'b0);     // Sets sticky
        run_op(16'h0002, 16'h0003, OP_ADD, 1'b0);     // Sticky held
        run_op(16'h00F0, 16'h0011, OP_AND, 1'b0);
        write_reg(REG_OPB, 32'h0000_0005, 1'b0);
        read_reg(REG_STATUS, status_word(), 1'b0);    // Valid dropped
        write_reg(REG_STATUS, 32'h0000_0000, 1'b0);   // Bit3 low, no clear
        read_reg(REG_STATUS, status_word(), 1'b0);
        write_reg(REG_STATUS, 32'h0000_0008, 1'b0);
        read_reg(REG_STATUS, status_word(), 1'b0);
        run_op(16'h0001, 16'h0001, OP_SUB, 1'b0);
        close_test();
    endtask

    initial begin
        rst_n    = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        exp_data = '0;
        exp_err  = 1'b0;
        chk_data = 1'b0;
        last_res = '0;
        valid_m  = 1'b0;
        sticky_m = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_and_map();
        arith_ops();
        logic_and_shift();
        setcond_ops();
        valid_and_sticky();

        repeat (2) @(posedge clk);                    // Let last checks settle
        $display("Tests: %0d ok, %0d with errors, %0d failed checks", ok_tests, bad_tests, errs);
        if (bad_tests == 0 && errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: design/alu_adder.sv
module alu_adder (
    input  logic signed [15:0] a,                     // First operand
    input  logic signed [15:0] b,                     // Second operand
    input  logic [2:0]         func,                  // Low code bits of arith class
    input  logic               coe_n,                 // Carry out enable, active low
    output logic [15:0]        sum,
    output logic               vout,
    output logic               cout
);

    logic        do_sub;                              // Subtract via inverted B
    logic        is_unsigned;                         // No overflow reported
    logic [15:0] b_sel;                               // B or constant one
    logic [15:0] b_add;                               // Operand actually added
    logic [16:0] total;                               // Sum with carry bit

    // Func map 000 add, 001 addu, 010 sub, 011 subu, 100 inc, 101 dec
    always_comb begin
        do_sub      = func[1] | (func[2] & func[0]);  // sub, subu, dec
        is_unsigned = func[0] & ~func[2];             // addu, subu
        b_sel       = func[2] ? 16'h0001 : b;         // inc and dec step by one
        b_add       = do_sub ? ~b_sel : b_sel;        // Two's complement with carry in
        total       = {1'b0, a} + {1'b0, b_add} + {16'd0, do_sub};
        sum         = total[15:0];

        // Overflow when both addends agree in sign and the sum does not
        vout = ~is_unsigned
             & (a[15] == b_add[15])
             & (total[15] != a[15]);

        cout = total[16] & ~coe_n;                    // Gated by enable
    end

endmodule

// File: design/alu_apb_top.sv
module alu_apb_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [alu_pkg::APB_AW-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [alu_pkg::APB_DW-1:0] pwdata,
    output logic [alu_pkg::APB_DW-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr
);

    import alu_pkg::*;

    alu_req_s  req;                                   // Registers to ALU
    alu_res_s  res;                                   // ALU to capture stage
    alu_stat_s stat;                                  // Captured state back to bus
    logic      sticky_clr;
    logic      operand_wr;

    apb_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .req        (req),
        .sticky_clr (sticky_clr),
        .operand_wr (operand_wr),
        .stat       (stat)
    );

    alu_core u_core (
        .req (req),
        .res (res)
    );

    result_stage u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .res        (res),
        .start      (req.start),                      // Strobe rides in the request
        .operand_wr (operand_wr),
        .sticky_clr (sticky_clr),
        .stat       (stat)
    );

endmodule

// File: design/alu_core.sv
module alu_core (
    input  alu_pkg::alu_req_s req,                    // Operands and code
    output alu_pkg::alu_res_s res                     // Result and flags
);

    import alu_pkg::*;

    logic [15:0]        add_sum;
    logic               add_vout;
    logic               add_cout;
    logic               arith_ok;                     // Func 110 and 111 are unused
    logic [15:0]        logic_r;
    logic [15:0]        shift_r;
    logic               cmp_r;
    logic signed [15:0] a_s;
    logic signed [15:0] b_s;
    logic [3:0]         shamt;
    alu_op_e            op;

    alu_adder u_adder (
        .a     (req.opa),
        .b     (req.opb),
        .func  (req.code.fields.func),                // Adder sees only func
        .coe_n (req.coe_n),
        .sum   (add_sum),
        .vout  (add_vout),
        .cout  (add_cout)
    );

    assign op       = alu_op_e'(req.code.raw);        // Full code for unit decode
    assign a_s      = $signed(req.opa);
    assign b_s      = $signed(req.opb);
    assign shamt    = req.opb[3:0];                   // Only low four bits count
    assign arith_ok = ~(req.code.fields.func[2] & req.code.fields.func[1]);

    // Logic unit
    always_comb begin
        case (op)
            OP_AND:  logic_r = req.opa & req.opb;
            OP_OR:   logic_r = req.opa | req.opb;
            OP_XOR:  logic_r = req.opa ^ req.opb;
            OP_NOT:  logic_r = ~req.opa;              // B ignored
            default: logic_r = 16'h0000;              // 01_011 and up
        endcase
    end

    // Shift unit
    always_comb begin
        case (op)
            OP_SLL:  shift_r = req.opa << shamt;
            OP_SRL:  shift_r = req.opa >> shamt;      // Zero fill
            OP_SLA:  shift_r = a_s <<< shamt;         // Same as sll
            OP_SRA:  shift_r = a_s >>> shamt;         // Sign fill
            default: shift_r = 16'h0000;
        endcase
    end

    // Compare unit
    always_comb begin
        case (op)
            OP_SLE:  cmp_r = (a_s <= b_s);
            OP_SLT:  cmp_r = (a_s <  b_s);
            OP_SGE:  cmp_r = (a_s >= b_s);
            OP_SGT:  cmp_r = (a_s >  b_s);
            OP_SEQ:  cmp_r = (a_s == b_s);
            OP_SNE:  cmp_r = (a_s != b_s);
            default: cmp_r = 1'b0;                    // 11_110 and 11_111
        endcase
    end

    // Class picks the unit; flags only from adder
    always_comb begin
        res = '0;
        unique case (req.code.fields.op_class)
            CLS_ARITH: begin
                if (arith_ok) begin
                    res.result = add_sum;
                    res.vout   = add_vout;
                    res.cout   = add_cout;
                end
            end
            CLS_LOGIC: begin
                res.result = logic_r;
            end
            CLS_SHIFT: begin
                res.result = shift_r;
            end
            CLS_SETCOND: begin
                res.result[0] = cmp_r;                // Upper bits stay zero
            end
        endcase
    end

endmodule

// File: design/alu_pkg.sv
package alu_pkg;

    localparam int APB_AW = 8;                        // APB address width
    localparam int APB_DW = 32;                       // APB data width

    typedef enum logic [4:0] {
        OP_ADD  = 5'b00_000,                          // Signed add
        OP_ADDU = 5'b00_001,                          // Unsigned add
        OP_SUB  = 5'b00_010,                          // Signed subtract
        OP_SUBU = 5'b00_011,                          // Unsigned subtract
        OP_INC  = 5'b00_100,                          // A plus one
        OP_DEC  = 5'b00_101,                          // A minus one
        OP_AND  = 5'b01_000,
        OP_OR   = 5'b01_001,
        OP_XOR  = 5'b01_010,
        OP_NOT  = 5'b01_100,                          // Inverts A only
        OP_SLL  = 5'b10_000,                          // Shifts take B[3:0]
        OP_SRL  = 5'b10_001,
        OP_SLA  = 5'b10_010,
        OP_SRA  = 5'b10_011,                          // Keeps sign of A
        OP_SLE  = 5'b11_000,                          // Compares are signed
        OP_SLT  = 5'b11_001,
        OP_SGE  = 5'b11_010,
        OP_SGT  = 5'b11_011,
        OP_SEQ  = 5'b11_100,
        OP_SNE  = 5'b11_101
    } alu_op_e;

    typedef enum logic [1:0] {
        CLS_ARITH   = 2'b00,                          // Goes through the adder
        CLS_LOGIC   = 2'b01,
        CLS_SHIFT   = 2'b10,
        CLS_SETCOND = 2'b11                           // Result is 0 or 1
    } alu_class_e;

    typedef struct packed {
        alu_class_e op_class;                         // Upper two code bits
        logic [2:0] func;                             // Function within class
    } alu_code_s;

    typedef union packed {
        logic [4:0] raw;                              // Code as written over APB
        alu_code_s  fields;                           // Same bits split by class
    } alu_code_u;

    typedef struct packed {
        logic signed [15:0] opa;
        logic signed [15:0] opb;
        alu_code_u          code;
        logic               coe_n;                    // Low enables carry out
        logic               start;                    // One cycle after CTRL write
    } alu_req_s;

    typedef struct packed {
        logic [15:0] result;
        logic        vout;                            // Signed overflow
        logic        cout;                            // Carry out of bit 15
    } alu_res_s;

    typedef struct packed {
        logic [15:0] result;
        logic        valid;                           // Result belongs to current inputs
        logic        vout;
        logic        cout;
        logic        ovf_sticky;                      // Held until STATUS write clears it
    } alu_stat_s;

    localparam logic [APB_AW-1:0] REG_OPA    = 8'h00;
    localparam logic [APB_AW-1:0] REG_OPB    = 8'h04;
    localparam logic [APB_AW-1:0] REG_CTRL   = 8'h08;
    localparam logic [APB_AW-1:0] REG_RESULT = 8'h0C;  // Read only
    localparam logic [APB_AW-1:0] REG_STATUS = 8'h10;

    localparam int CTRL_COE_BIT   = 8;                // Code sits in bits 4:0
    localparam int STAT_VALID_BIT = 0;
    localparam int STAT_VOUT_BIT  = 1;
    localparam int STAT_COUT_BIT  = 2;
    localparam int STAT_OVF_BIT   = 3;                // Write 1 here to clear sticky

endpackage

// File: design/apb_regs.sv
module apb_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [alu_pkg::APB_AW-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [alu_pkg::APB_DW-1:0] pwdata,
    output logic [alu_pkg::APB_DW-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    output alu_pkg::alu_req_s          req,        // Held operands plus start
    output logic                       sticky_clr, // One cycle pulse
    output logic                       operand_wr, // One cycle pulse
    input  alu_pkg::alu_stat_s         stat        // For the read mux
);

    import alu_pkg::*;

    logic access;                                     // APB access phase
    logic addr_ok;                                    // Offset is mapped
    logic wr_ok;                                      // Write accepted
    logic wr_opa;
    logic wr_opb;
    logic wr_ctrl;
    logic wr_stat;

    assign access = psel & penable;
    assign pready = 1'b1;                             // Never any wait states

    always_comb begin
        case (paddr)
            REG_OPA, REG_OPB, REG_CTRL,
            REG_RESULT, REG_STATUS: addr_ok = 1'b1;
            default:                addr_ok = 1'b0;
        endcase
    end

    // Error on unmapped offset or write to RESULT
    assign pslverr = access & (~addr_ok | (pwrite & (paddr == REG_RESULT)));

    assign wr_ok   = access & pwrite & ~pslverr;
    assign wr_opa  = wr_ok & (paddr == REG_OPA);
    assign wr_opb  = wr_ok & (paddr == REG_OPB);
    assign wr_ctrl = wr_ok & (paddr == REG_CTRL);
    assign wr_stat = wr_ok & (paddr == REG_STATUS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req        <= '0;
            sticky_clr <= 1'b0;
            operand_wr <= 1'b0;
        end else begin
            req.start  <= wr_ctrl;                    // ALU inputs already settled then
            operand_wr <= wr_opa | wr_opb;
            sticky_clr <= wr_stat & pwdata[STAT_OVF_BIT];
            if (wr_opa) begin
                req.opa <= pwdata[15:0];
            end
            if (wr_opb) begin
                req.opb <= pwdata[15:0];
            end
            if (wr_ctrl) begin
                req.code.raw <= pwdata[$bits(alu_code_u)-1:0];
                req.coe_n    <= pwdata[CTRL_COE_BIT];
            end
        end
    end

    // Read data only in read access phase
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                REG_OPA:    prdata[15:0] = req.opa;   // Zero extended
                REG_OPB:    prdata[15:0] = req.opb;
                REG_CTRL: begin
                    prdata[$bits(alu_code_u)-1:0] = req.code.raw;
                    prdata[CTRL_COE_BIT]          = req.coe_n;
                end
                REG_RESULT: prdata[15:0] = stat.result;
                REG_STATUS: begin
                    prdata[STAT_VALID_BIT] = stat.valid;
                    prdata[STAT_VOUT_BIT]  = stat.vout;
                    prdata[STAT_COUT_BIT]  = stat.cout;
                    prdata[STAT_OVF_BIT]   = stat.ovf_sticky;
                end
                default:    prdata = '0;
            endcase
        end
    end

    // Host must hold psel through the access phase
    a_penable_psel : assert property (
        @(posedge clk) disable iff (!rst_n) penable |-> psel
    ) else $error("apb_regs: penable high without psel");

endmodule

// File: design/result_stage.sv
module result_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  alu_pkg::alu_res_s  res,                   // Combinational ALU output
    input  logic               start,                 // Capture strobe
    input  logic               operand_wr,            // Inputs changed since capture
    input  logic               sticky_clr,            // From STATUS write
    output alu_pkg::alu_stat_s stat
);

    logic valid_nxt;
    logic sticky_nxt;

    // Start sets valid; a later operand write drops it
    always_comb begin
        if (start) begin
            valid_nxt = 1'b1;
        end else if (operand_wr) begin
            valid_nxt = 1'b0;
        end else begin
            valid_nxt = stat.valid;
        end
    end

    // Clear first, then a fresh overflow can set it again
    assign sticky_nxt = (stat.ovf_sticky & ~sticky_clr) | (start & res.vout);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stat <= '0;                               // RESULT reads zero after reset
        end else begin
            stat.valid      <= valid_nxt;
            stat.ovf_sticky <= sticky_nxt;
            if (start) begin
                stat.result <= res.result;
                stat.vout   <= res.vout;
                stat.cout   <= res.cout;
            end
        end
    end

    // Only a start strobe can make the result valid
    a_valid_after_start : assert property (
        @(posedge clk) disable iff (!rst_n) $rose(stat.valid) |-> $past(start)
    ) else $error("result_stage: valid rose without start");

endmodule

// File: run.sh
#!/bin/sh
# Build and run the ALU APB testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary -f tb.f --top-module alu_tb -o alu_sim

./obj_dir/alu_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run.sh: failure reported in sim.log"
    exit 1
fi

echo "run.sh: no failure reported in sim.log"
exit 0

// File: tb.f
design/alu_pkg.sv
design/alu_adder.sv
design/alu_core.sv
design/apb_regs.sv
design/result_stage.sv
design/alu_apb_top.sv
bench/alu_tb.sv
